/* hw/spi_bridge_pkg.sv */
// spi bridge constants and the payload types shared by the command and receive paths.
package spi_bridge_pkg;

  // bits moved per transfer, msb first.
  localparam int spi_width = 8;

  // wide enough to hold a count of 0 to spi_width.
  localparam int spi_cnt_w = $clog2(spi_width + 1);

  // clk200 cycles per half sclk period, so one spi bit takes 8 cycles.
  localparam int sclk_half = 4;

  localparam int sclk_cnt_w = $clog2(sclk_half); // half period counter width.

  // entries in each of the two buffers.
  localparam int fifo_depth = 4;

  // one byte on the wire in either direction.
  typedef logic [spi_width-1:0] spi_byte_t;

  // Command word as the host pushes it.
  typedef struct packed {
    spi_byte_t data; // byte shifted out on mosi.
    logic      keep; // store the byte read back in the receive buffer.
  } spi_cmd_t;

endpackage

/* hw/sclk_gen.sv */
`timescale 1ns/1ns
// spi clock generator that divides clk200 while running and flags each sclk edge.
module sclk_gen (
  input  logic clk200,
  input  logic nrst_once,
  input  logic run,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);
  import spi_bridge_pkg::*;

  logic [sclk_cnt_w-1:0] half_cnt;
  logic                  half_done;

  assign half_done = (half_cnt == sclk_cnt_w'(sclk_half - 1)); // last cycle of a half period.

  always_ff @(posedge clk200) begin
    if (!nrst_once) begin
      half_cnt  <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end else if (!run) begin
      half_cnt  <= '0; // the next run opens with a full low half period.
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end else begin
      sclk_rise <= half_done && !sclk; // strobes line up with the new sclk level.
      sclk_fall <= half_done && sclk;
      if (half_done) begin
        half_cnt <= '0;
        sclk     <= ~sclk;
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // The core only drops run after a falling edge, so sclk is already low by then.
  assert property (@(posedge clk200) disable iff (!nrst_once)
    !run |-> !sclk);

endmodule

/* hw/byte_fifo.sv */
`timescale 1ns/1ns
// synchronous first-word-fall-through fifo with a typed payload and a set depth.
module byte_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     clk200,
  input  logic     nrst_once,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     full
);
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  // pointers wrap at depth, which need not be a power of two.
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk200) begin
    if (push) begin
      mem[wr_ptr] <= push_data; // shows at the head one cycle later.
    end
  end

  always_ff @(posedge clk200) begin
    if (!nrst_once) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // push and pop together leave the level alone.
      endcase
    end
  end

  assign head  = mem[rd_ptr]; // oldest entry, valid while empty is low.
  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

  // The writer must respect full.
  assert property (@(posedge clk200) disable iff (!nrst_once)
    push |-> !full);

  // The reader must respect empty.
  assert property (@(posedge clk200) disable iff (!nrst_once)
    pop |-> !empty);

endmodule

/* hw/spi_master_core.sv */
`timescale 1ns/1ns
// spi mode 0 master core that runs one full-duplex byte transfer per popped command.
module spi_master_core (
  input  logic                      clk200,
  input  logic                      nrst_once,
  input  spi_bridge_pkg::spi_cmd_t  cmd_head,
  input  logic                      cmd_empty,
  output logic                      cmd_pop,
  input  logic                      rx_full,
  output logic                      rx_push,
  output spi_bridge_pkg::spi_byte_t rx_byte,
  output logic                      sclk_run,
  input  logic                      sclk_rise,
  input  logic                      sclk_fall,
  output logic                      ncs,
  output logic                      mosi,
  input  logic                      miso,
  output logic                      busy
);
  import spi_bridge_pkg::*;

  typedef enum logic [1:0] {
    st_idle,   // ncs high, waiting for a command.
    st_shift,  // ncs low, bits moving on each sclk edge.
    st_finish  // all bits sampled, waiting for the last falling edge.
  } state_t;

  state_t               state;
  spi_byte_t            tx_sr;
  spi_byte_t            rx_sr;
  logic [spi_cnt_w-1:0] bit_cnt;
  logic                 keep;

  // A kept read needs a free slot, counting the push that may still be in flight.
  assign cmd_pop = (state == st_idle) && !cmd_empty &&
                   (!cmd_head.keep || (!rx_full && !rx_push));

  assign mosi    = tx_sr[spi_width-1]; // msb leads from the first ncs low cycle.
  assign rx_byte = rx_sr;
  assign busy    = cmd_pop || (state != st_idle);

  always_ff @(posedge clk200) begin
    if (!nrst_once) begin
      state    <= st_idle;
      ncs      <= 1'b1;
      sclk_run <= 1'b0;
      rx_push  <= 1'b0;
      bit_cnt  <= '0;
      keep     <= 1'b0;
    end else begin
      rx_push <= 1'b0; // single cycle pulse.
      case (state)
        st_idle: begin
          if (cmd_pop) begin
            state    <= st_shift;
            ncs      <= 1'b0;
            sclk_run <= 1'b1;
            bit_cnt  <= '0;
            keep     <= cmd_head.keep;
          end
        end
        st_shift: begin
          if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == spi_cnt_w'(spi_width - 1)) begin
              state <= st_finish; // that was the last sample.
            end
          end
        end
        st_finish: begin
          if (sclk_fall) begin
            state    <= st_idle;
            ncs      <= 1'b1;
            sclk_run <= 1'b0;
            rx_push  <= keep; // the read byte is complete in rx_sr here.
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // mosi moves out on falling edges, miso comes in on rising edges.
  always_ff @(posedge clk200) begin
    if (cmd_pop) begin
      tx_sr <= cmd_head.data;
    end else if ((state == st_shift) && sclk_fall) begin
      tx_sr <= {tx_sr[spi_width-2:0], 1'b0}; // next bit ready before the next rise.
    end
    if ((state == st_shift) && sclk_rise) begin
      rx_sr <= {rx_sr[spi_width-2:0], miso};
    end
  end

  // every sclk edge of a byte falls inside the ncs low window.
  assert property (@(posedge clk200) disable iff (!nrst_once)
    (sclk_rise || sclk_fall) |-> !ncs);

  // The receive buffer never overflows from a kept read.
  assert property (@(posedge clk200) disable iff (!nrst_once)
    rx_push |-> !rx_full);

endmodule

/* hw/spi_bridge_top.sv */
`timescale 1ns/1ns
// spi bridge top joining the command fifo, sclk generator, master core and receive fifo.
module spi_bridge_top (
  input  logic                      clk200,
  input  logic                      nrst_once,
  input  logic                      cmd_push,
  input  spi_bridge_pkg::spi_cmd_t  cmd_data,
  output logic                      cmd_full,
  input  logic                      rx_pop,
  output spi_bridge_pkg::spi_byte_t rx_data,
  output logic                      rx_empty,
  output logic                      busy,
  output logic                      sclk,
  output logic                      ncs,
  output logic                      mosi,
  input  logic                      miso
);
  import spi_bridge_pkg::*;

  spi_cmd_t  cmd_head;
  logic      cmd_empty;
  logic      cmd_pop;
  logic      rx_push;
  spi_byte_t rx_byte;
  logic      rx_full;
  logic      sclk_run;
  logic      sclk_rise;
  logic      sclk_fall;

  byte_fifo #(
    .payload_t (spi_cmd_t),
    .depth     (fifo_depth)
  ) cmd_fifo_inst (
    .clk200    (clk200),
    .nrst_once (nrst_once),
    .push      (cmd_push),
    .push_data (cmd_data),
    .pop       (cmd_pop),
    .head      (cmd_head),
    .empty     (cmd_empty),
    .full      (cmd_full)
  );

  sclk_gen sclk_gen_inst (
    .clk200    (clk200),
    .nrst_once (nrst_once),
    .run       (sclk_run),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  spi_master_core spi_master_core_inst (
    .clk200    (clk200),
    .nrst_once (nrst_once),
    .cmd_head  (cmd_head),
    .cmd_empty (cmd_empty),
    .cmd_pop   (cmd_pop),
    .rx_full   (rx_full),
    .rx_push   (rx_push),
    .rx_byte   (rx_byte),
    .sclk_run  (sclk_run),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .ncs       (ncs),
    .mosi      (mosi),
    .miso      (miso),
    .busy      (busy)
  );

  byte_fifo #(
    .payload_t (spi_byte_t),
    .depth     (fifo_depth)
  ) rx_fifo_inst (
    .clk200    (clk200),
    .nrst_once (nrst_once),
    .push      (rx_push),
    .push_data (rx_byte),
    .pop       (rx_pop),
    .head      (rx_data),
    .empty     (rx_empty),
    .full      (rx_full)
  );

endmodule

/* verification/spi_slave_model.sv */
`timescale 1ns/1ns
// spi mode 0 device model that logs each received byte and answers with the previous one inverted.
module spi_slave_model (
  input  logic                      ncs,
  input  logic                      sclk,
  input  logic                      mosi,
  output logic                      miso,
  output int                        rx_count,
  output spi_bridge_pkg::spi_byte_t rx_last
);
  import spi_bridge_pkg::*;

  spi_byte_t rx_q [$]; // every complete byte, oldest first.
  spi_byte_t reply;
  spi_byte_t tx_sr;
  spi_byte_t rx_sr;
  int        nbits;

  initial begin
    miso     = 1'b0;
    rx_count = 0;
    rx_last  = '0;
    reply    = 8'h5a; // answer for the first transfer after reset.
    forever begin
      @(negedge ncs);
      tx_sr = reply;
      rx_sr = '0;
      nbits = 0;
      miso  = tx_sr[spi_width-1]; // msb is on the line before the first rise.
      while (!ncs) begin
        @(sclk or ncs);
        if (!ncs && sclk) begin
          rx_sr = {rx_sr[spi_width-2:0], mosi}; // sample on the rising edge.
          nbits = nbits + 1;
        end else if (!ncs && !sclk) begin
          tx_sr = {tx_sr[spi_width-2:0], 1'b0};
          miso  = tx_sr[spi_width-1]; // next bit after the falling edge.
        end
      end
      // A frame cut short is not a byte.
      if (nbits == spi_width) begin
        rx_q.push_back(rx_sr);
        rx_last  = rx_sr;
        rx_count = rx_q.size();
        reply    = ~rx_sr;
      end
    end
  end

endmodule

/* verification/spi_bridge_tb.sv */
`timescale 1ns/1ns
// testbench for the spi bridge that replays command vectors and checks both spi directions.
module spi_bridge_tb;
  import spi_bridge_pkg::*;

  localparam int          clk_period   = 4;
  localparam int          reset_cycles = 10;
  localparam logic [31:0] rng_seed     = 32'h2624;
  localparam int          max_vec      = 64;
  localparam int          idle_cycles  = 16; // longer than any pause between queued transfers.

  logic        clk200;
  logic        nrst_once;
  logic        cmd_push;
  spi_cmd_t    cmd_data;
  logic        cmd_full;
  logic        rx_pop;
  spi_byte_t   rx_data;
  logic        rx_empty;
  logic        busy;
  logic        sclk;
  logic        ncs;
  logic        mosi;
  logic        miso;
  int          slave_count;
  spi_byte_t   slave_last;
  spi_cmd_t    vec_cmd [max_vec];
  spi_byte_t   vec_exp [max_vec];
  int          nvec;
  logic        vectors_loaded;
  logic [31:0] rng_state;
  spi_byte_t   sent_q [$]; // mosi bytes in push order.
  int          frames_seen;
  int          rise_cnt;
  logic        prev_ncs;
  logic        prev_sclk;

  spi_bridge_top spi_bridge_top_inst (
    .clk200    (clk200),
    .nrst_once (nrst_once),
    .cmd_push  (cmd_push),
    .cmd_data  (cmd_data),
    .cmd_full  (cmd_full),
    .rx_pop    (rx_pop),
    .rx_data   (rx_data),
    .rx_empty  (rx_empty),
    .busy      (busy),
    .sclk      (sclk),
    .ncs       (ncs),
    .mosi      (mosi),
    .miso      (miso)
  );

  spi_slave_model slave_inst (
    .ncs      (ncs),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .rx_count (slave_count),
    .rx_last  (slave_last)
  );

  initial begin
    clk200 = 1'b0;
    forever #(clk_period / 2) clk200 = ~clk200;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_byte(input string name, input spi_byte_t expected, input spi_byte_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("** Error at %0t ns: %s expected %h, actual %h",
                               $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("** Error at %0t ns: %s expected %b, actual %b",
                               $time, name, expected, actual));
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic idle_gap();
    int gap;
    rng_state = lcg_next(rng_state);
    gap = int'(rng_state[19:16]); // 0 to 15 cycles.
    repeat (gap) @(negedge clk200);
  endtask

  task automatic load_vectors();
    int    fd;
    int    code;
    int    d;
    int    k;
    int    e;
    string line;
    fd = $fopen("verification/spi_bridge_vectors.txt", "r");
    if (fd == 0) begin
      report_failure("the vector file could not be opened");
    end
    nvec = 0;
    while (!$feof(fd) && nvec < max_vec) begin
      line = "";
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%h %h %h", d, k, e) == 3) begin
          vec_cmd[nvec].data = d[7:0];
          vec_cmd[nvec].keep = k[0];
          vec_exp[nvec]      = e[7:0];
          nvec = nvec + 1;
        end
      end
    end
    $fclose(fd);
    if (nvec < fifo_depth + 2) begin
      report_failure("the vector file holds too few commands");
    end
  endtask

  task automatic push_cmd(input spi_cmd_t c);
    while (cmd_full) @(negedge clk200);
    cmd_data = c;
    cmd_push = 1'b1;
    sent_q.push_back(c.data);
    @(negedge clk200);
    cmd_push = 1'b0;
  endtask

  task automatic pop_check(input spi_byte_t expected);
    while (rx_empty) @(negedge clk200);
    check_byte("rx_data", expected, rx_data);
    rx_pop = 1'b1;
    @(negedge clk200);
    rx_pop = 1'b0;
  endtask

  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < idle_cycles) begin
      @(negedge clk200);
      quiet = busy ? 0 : quiet + 1;
    end
  endtask

  task automatic run_stream(input int count);
    int kept_q [$];
    for (int i = 0; i < count; i++) begin
      if (vec_cmd[i].keep) begin
        kept_q.push_back(i);
      end
    end
    fork
      begin
        for (int i = 0; i < count; i++) begin
          idle_gap();
          push_cmd(vec_cmd[i]);
        end
      end
      begin
        for (int j = 0; j < kept_q.size(); j++) begin
          idle_gap();
          pop_check(vec_exp[kept_q[j]]);
        end
      end
    join
    wait_idle();
    check_bit("rx_empty", 1'b1, rx_empty); // unkept reads left nothing behind.
    check_byte("slave byte count", spi_byte_t'(count), spi_byte_t'(slave_count));
  endtask

  task automatic run_backpressure(input int first);
    int base;
    base = slave_count;
    for (int i = 0; i <= fifo_depth; i++) begin
      if (!vec_cmd[first + i].keep) begin
        report_failure("a back-pressure vector does not keep its read byte");
      end
      push_cmd(vec_cmd[first + i]);
    end
    check_bit("cmd_full", 1'b1, cmd_full); // one is in flight, the rest fill the buffer.
    wait_idle(); // last command is stuck behind the full receive buffer.
    check_bit("rx_empty", 1'b0, rx_empty);
    check_byte("slave byte count", spi_byte_t'(fifo_depth), spi_byte_t'(slave_count - base));
    pop_check(vec_exp[first]);
    wait_idle();
    check_byte("slave byte count", spi_byte_t'(fifo_depth + 1), spi_byte_t'(slave_count - base));
    for (int i = 1; i <= fifo_depth; i++) begin
      pop_check(vec_exp[first + i]);
    end
    check_bit("rx_empty", 1'b1, rx_empty);
  endtask

  // Framing and write path are watched on every falling clk200 edge.
  always @(negedge clk200) begin
    if (nrst_once) begin
      if (ncs) begin
        check_bit("sclk", 1'b0, sclk); // idle level while deselected.
      end else if (sclk && !prev_sclk) begin
        rise_cnt = rise_cnt + 1;
      end
      if (ncs && !prev_ncs) begin
        if (frames_seen >= sent_q.size()) begin
          report_failure("a transfer ran without a pushed command");
        end
        check_byte("sclk rises per frame", spi_byte_t'(spi_width), spi_byte_t'(rise_cnt));
        check_byte("slave received byte", sent_q[frames_seen], slave_last);
        frames_seen = frames_seen + 1;
        rise_cnt    = 0;
      end
    end
    prev_ncs  = ncs;
    prev_sclk = sclk;
  end

  initial begin
    nrst_once      = 1'b0;
    cmd_push       = 1'b0;
    cmd_data       = '0;
    rx_pop         = 1'b0;
    vectors_loaded = 1'b0;
    rng_state      = rng_seed;
    frames_seen    = 0;
    rise_cnt       = 0;
    prev_ncs       = 1'b1;
    prev_sclk      = 1'b0;
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (reset_cycles) @(negedge clk200);
    nrst_once = 1'b1;
    @(negedge clk200);
    check_bit("ncs", 1'b1, ncs);
    check_bit("sclk", 1'b0, sclk);
    check_bit("busy", 1'b0, busy);
    check_bit("cmd_full", 1'b0, cmd_full);
    check_bit("rx_empty", 1'b1, rx_empty);
    run_stream(nvec - (fifo_depth + 1));
    run_backpressure(nvec - (fifo_depth + 1));
    $display("All checks passed");
    $finish;
  end

  // Each transfer needs about 70 cycles, so 80 per vector leaves room for the gaps.
  initial begin
    wait (vectors_loaded);
    #((nvec * 80 + reset_cycles + 1000) * clk_period);
    report_failure("the watchdog expired before the tests finished");
  end

endmodule

/* verification/spi_bridge_vectors.txt */
# columns: mosi byte (hex), keep flag, expected read byte (hex)
# the read byte is the previous mosi byte inverted, 5a for the first transfer
a5 1 5a
3c 0 5a
81 1 c3
7e 1 7e
00 0 81
ff 1 ff
12 1 00
34 0 ed
56 1 cb
9a 1 a9
c7 0 65
e1 1 38
0f 1 1e
f0 0 f0
69 1 0f
96 1 96
2b 1 69
d4 1 d4
4e 1 2b
b1 1 b1

/* sources.f */
hw/spi_bridge_pkg.sv
hw/sclk_gen.sv
hw/byte_fifo.sv
hw/spi_master_core.sv
hw/spi_bridge_top.sv
verification/spi_slave_model.sv
verification/spi_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the spi bridge testbench with Verilator, runs it and judges the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module spi_bridge_tb \
  -f sources.f -o spi_bridge_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/spi_bridge_sim > sim.log 2>&1 || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation FAILED"; exit 1; } || echo "simulation ok"
